// File: common/cpu8_macros.svh
// widths are fixed for the 8-bit core; changing them needs matching changes to the instruction layout
`ifndef CPU8_MACROS_SVH
`define CPU8_MACROS_SVH

// datapath width
`define DATA_W 8

// register file geometry, entry 0 hardwired to zero
`define REG_ADDR_W 3
`define REG_COUNT 8

// instruction word and immediate field
`define INSTR_W 16
`define IMM_W 6

`endif

// File: common/cpu8_pkg.sv
// instruction layout assumes INSTR_W 16 with a 4-bit opcode and 3-bit register fields
`include "cpu8_macros.svh"

package cpu8_pkg;

    // codes 5 to 15 are illegal and retire nothing
    typedef enum logic [3:0] {
        OP_NOP     = 4'd0,
        OP_ALU_REG = 4'd1,
        OP_ADDI    = 4'd2,
        OP_ANDI    = 4'd3,
        OP_XORI    = 4'd4
    } opcode_e;

    // order matches the funct encoding of the register form
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SHL = 3'd5,
        ALU_SHR = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // register form, rd = rs1 funct rs2
    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [2:0]             funct;
    } instr_reg_t;

    // immediate form, imm is two's complement
    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`IMM_W-1:0]      imm;
    } instr_imm_t;

    // same 16 bits, low six decoded by opcode
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    // decode to execute
    typedef struct packed {
        logic                   valid;
        logic                   writes;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic                   uses_rs2;
        logic [`DATA_W-1:0]     op_a;
        logic [`DATA_W-1:0]     op_b;
        logic [`DATA_W-1:0]     imm;
        logic                   use_imm;
        alu_op_e                alu_op;
    } id_ex_t;

    // execute to writeback, also the bank write port
    typedef struct packed {
        logic                   writes;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`DATA_W-1:0]     result;
    } ex_wb_t;

endpackage

// File: rtl/reg_bank.sv
// register 0 has no storage and reads zero; reads are combinational and a same-cycle write passes through
`timescale 1ns/10ps
`include "cpu8_macros.svh"

module reg_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en_n,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`DATA_W-1:0]     wr_data,
    input  logic [`REG_ADDR_W-1:0] ra1,
    input  logic [`REG_ADDR_W-1:0] ra2,
    output logic [`DATA_W-1:0]     rd1,
    output logic [`DATA_W-1:0]     rd2
);

    // entries 1 to 7 only
    logic [`DATA_W-1:0] regs [1:`REG_COUNT-1];
    // write that actually lands in storage
    logic               wr_live;

    // active low enable, address 0 dropped
    assign wr_live = !wr_en_n && (wr_addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // zero reg first, then bypass, then storage
    function automatic logic [`DATA_W-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        logic [`DATA_W-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wr_live && (addr == wr_addr)) begin
            val = wr_data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

    // write address comes from the execute stage register
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !wr_en_n |-> !$isunknown(wr_addr)
    ) else $error("reg_bank write with unknown address");

endmodule

// File: rtl/decode_stage.sv
// illegal opcodes decode as NOP; operands are read from the bank in the same cycle the instruction arrives
`timescale 1ns/10ps
`include "cpu8_macros.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  cpu8_pkg::instr_t       instr,
    input  logic [`DATA_W-1:0]     rd_a,
    input  logic [`DATA_W-1:0]     rd_b,
    output logic [`REG_ADDR_W-1:0] ra,
    output logic [`REG_ADDR_W-1:0] rb,
    output cpu8_pkg::id_ex_t       id_ex
);

    import cpu8_pkg::*;

    // next value of the pipeline register
    id_ex_t             id_ex_d;
    // opcode is in the same place in both views
    opcode_e            opcode;
    logic               legal;
    logic               uses_rs2;
    logic               use_imm;
    alu_op_e            alu_op;
    logic [`DATA_W-1:0] imm_ext;

    assign opcode = instr.r.opcode;

    // opcode decides which view of the word is meaningful
    always_comb begin
        legal    = 1'b0;
        uses_rs2 = 1'b0;
        use_imm  = 1'b0;
        alu_op   = ALU_ADD;
        imm_ext  = '0;
        case (opcode)
            OP_ALU_REG: begin
                legal    = 1'b1;
                uses_rs2 = 1'b1;
                // funct maps one to one onto the alu ops
                alu_op   = alu_op_e'(instr.r.funct);
            end
            OP_ADDI, OP_ANDI, OP_XORI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                imm_ext = {{(`DATA_W-`IMM_W){instr.i.imm[`IMM_W-1]}}, instr.i.imm};
                if (opcode == OP_ANDI) begin
                    alu_op = ALU_AND;
                end else if (opcode == OP_XORI) begin
                    alu_op = ALU_XOR;
                end else begin
                    alu_op = ALU_ADD;
                end
            end
            // NOP and the illegal codes
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // bank read addresses, rb idle for immediate forms
    assign ra = instr.r.rs1;
    assign rb = uses_rs2 ? instr.r.rs2 : '0;

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.valid    = instr_valid;
        // rd 0 would be dropped by the bank anyway, flag it off here
        id_ex_d.writes   = legal && (instr.r.rd != '0);
        id_ex_d.rd       = instr.r.rd;
        id_ex_d.rs1      = ra;
        id_ex_d.rs2      = rb;
        id_ex_d.uses_rs2 = uses_rs2;
        id_ex_d.op_a     = rd_a;
        id_ex_d.op_b     = rd_b;
        id_ex_d.imm      = imm_ext;
        id_ex_d.use_imm  = use_imm;
        id_ex_d.alu_op   = alu_op;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

    // strobe from the outside source must be clean
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(instr_valid)
    ) else $error("instr_valid is unknown");

endmodule

// File: rtl/execute_stage.sv
// forwards only from the instruction one slot ahead; older results must come through the bank
`timescale 1ns/10ps
`include "cpu8_macros.svh"

module execute_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu8_pkg::id_ex_t id_ex,
    output cpu8_pkg::ex_wb_t ex_wb
);

    import cpu8_pkg::*;

    localparam int SHAMT_W = $clog2(`DATA_W);

    // forward hits against the retiring instruction
    logic               fwd_a;
    logic               fwd_b;
    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b;
    logic [SHAMT_W-1:0] shamt;
    logic [`DATA_W-1:0] result;
    ex_wb_t             ex_wb_d;

    // ex_wb.writes is already clear for rd 0 and bubbles
    assign fwd_a = ex_wb.writes && (ex_wb.rd == id_ex.rs1);
    assign fwd_b = ex_wb.writes && id_ex.uses_rs2 && (ex_wb.rd == id_ex.rs2);

    // operand a
    assign op_a = fwd_a ? ex_wb.result : id_ex.op_a;

    // operand b, immediate wins over the register path
    always_comb begin
        if (id_ex.use_imm) begin
            op_b = id_ex.imm;
        end else if (fwd_b) begin
            op_b = ex_wb.result;
        end else begin
            op_b = id_ex.op_b;
        end
    end

    // low bits of b only
    assign shamt = op_b[SHAMT_W-1:0];

    // all ops wrap at 8 bits
    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SHL: result = op_a << shamt;
            ALU_SHR: result = op_a >> shamt;
            // unsigned compare, 1 or 0
            ALU_SLT: result = {{(`DATA_W-1){1'b0}}, (op_a < op_b)};
            default: result = '0;
        endcase
    end

    always_comb begin
        // bubbles never write
        ex_wb_d.writes = id_ex.valid && id_ex.writes;
        ex_wb_d.rd     = id_ex.rd;
        ex_wb_d.result = result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_wb <= '0;
        end else begin
            ex_wb <= ex_wb_d;
        end
    end

    // decode must never flag a write to the zero register
    a_no_write_r0: assert property (
        @(posedge clk) disable iff (!rst_n)
        id_ex.writes |-> (id_ex.rd != '0)
    ) else $error("id_ex flags a write to r0");

endmodule

// File: rtl/cpu8_core.sv
// no stalls and no back-pressure; each instruction retires exactly two edges after it is sampled
`timescale 1ns/10ps
`include "cpu8_macros.svh"

module cpu8_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  cpu8_pkg::instr_t       instr,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_dest,
    output logic [`DATA_W-1:0]     wb_data
);

    import cpu8_pkg::*;

    // bank read side, driven by decode
    logic [`REG_ADDR_W-1:0] ra;
    logic [`REG_ADDR_W-1:0] rb;
    logic [`DATA_W-1:0]     rd_a;
    logic [`DATA_W-1:0]     rd_b;
    // stage registers
    id_ex_t                 id_ex;
    ex_wb_t                 ex_wb;
    logic                   wr_en_n;

    // writeback register drives the bank, enable is active low
    assign wr_en_n = !ex_wb.writes;

    // retired writes are visible at the ports
    assign wb_valid = ex_wb.writes;
    assign wb_dest  = ex_wb.rd;
    assign wb_data  = ex_wb.result;

    reg_bank u_reg_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en_n (wr_en_n),
        .wr_addr (ex_wb.rd),
        .wr_data (ex_wb.result),
        .ra1     (ra),
        .ra2     (rb),
        .rd1     (rd_a),
        .rd2     (rd_b)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .ra          (ra),
        .rb          (rb),
        .id_ex       (id_ex)
    );

    execute_stage u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .id_ex (id_ex),
        .ex_wb (ex_wb)
    );

endmodule

// File: tests/cpu8_tb.sv
// each row is checked two edges after it is sampled; expected values assume every register clears at reset
`timescale 1ns/10ps
`include "cpu8_macros.svh"

module cpu8_tb;

    import cpu8_pkg::*;

    localparam int N_DIRECTED  = 33;
    localparam int N_RANDOM    = 64;
    localparam int TAB_LEN     = N_DIRECTED + N_RANDOM;
    // table plus reset and drain with margin
    localparam int CYCLE_LIMIT = TAB_LEN + 20;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   instr_valid;
    instr_t                 instr;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_dest;
    logic [`DATA_W-1:0]     wb_data;

    // stimulus and expected retirement per row
    logic                   tab_valid     [TAB_LEN];
    logic [`INSTR_W-1:0]    tab_instr     [TAB_LEN];
    logic                   tab_exp_valid [TAB_LEN];
    logic [`REG_ADDR_W-1:0] tab_exp_dest  [TAB_LEN];
    logic [`DATA_W-1:0]     tab_exp_data  [TAB_LEN];
    string                  tab_label     [TAB_LEN];
    int                     n_rows = 0;

    // architectural state as the in-order model sees it
    logic [`DATA_W-1:0]     model_regs [`REG_COUNT];
    logic [31:0]            seed = 32'haac;

    int cur_row      = 0;
    int checks       = 0;
    int errors       = 0;
    int cycles       = 0;
    // per-group bookkeeping
    int group_first  = 0;
    int group_errors = 0;

    cpu8_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // hard stop if the run never reaches its end
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // register form word
    function automatic logic [`INSTR_W-1:0] reg_form(input logic [2:0] funct,
                                                    input logic [2:0] rd,
                                                    input logic [2:0] rs1,
                                                    input logic [2:0] rs2);
        return {OP_ALU_REG, rd, rs1, rs2, funct};
    endfunction

    // builds immediate forms and illegal opcodes
    function automatic logic [`INSTR_W-1:0] imm_form(input logic [3:0] op,
                                                    input logic [2:0] rd,
                                                    input logic [2:0] rs1,
                                                    input logic [5:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    // alu result straight from the opcode and funct definitions
    function automatic logic [`DATA_W-1:0] model_alu(input logic [`INSTR_W-1:0] word,
                                                     input logic [`DATA_W-1:0] a,
                                                     input logic [`DATA_W-1:0] b);
        logic [`DATA_W-1:0] imm;
        logic [`DATA_W-1:0] res;
        imm = {{(`DATA_W-`IMM_W){word[`IMM_W-1]}}, word[`IMM_W-1:0]};
        res = '0;
        case (word[15:12])
            OP_ALU_REG: begin
                case (word[2:0])
                    3'd0: res = a + b;
                    3'd1: res = a - b;
                    3'd2: res = a & b;
                    3'd3: res = a | b;
                    3'd4: res = a ^ b;
                    3'd5: res = a << b[2:0];
                    3'd6: res = a >> b[2:0];
                    default: res = (a < b) ? 8'd1 : 8'd0;
                endcase
            end
            OP_ADDI: res = a + imm;
            OP_ANDI: res = a & imm;
            OP_XORI: res = a ^ imm;
            default: res = '0;
        endcase
        return res;
    endfunction

    // legal opcode, nonzero rd and a real strobe
    function automatic logic model_writes(input logic v, input logic [`INSTR_W-1:0] word);
        logic legal;
        legal = (word[15:12] >= 4'd1) && (word[15:12] <= 4'd4);
        return v && legal && (word[11:9] != 3'd0);
    endfunction

    task automatic add_row(input logic v, input logic [`INSTR_W-1:0] word, input logic ev,
                           input logic [`REG_ADDR_W-1:0] ed, input logic [`DATA_W-1:0] edata,
                           input string label);
        tab_valid[n_rows]     = v;
        tab_instr[n_rows]     = word;
        tab_exp_valid[n_rows] = ev;
        tab_exp_dest[n_rows]  = ed;
        tab_exp_data[n_rows]  = edata;
        tab_label[n_rows]     = label;
        // retired writes move the model forward
        if (ev && (ed != '0)) begin
            model_regs[ed] = edata;
        end
        n_rows++;
    endtask

    // expected values taken from the model state at this point in the stream
    task automatic add_model_row(input logic v, input logic [`INSTR_W-1:0] word,
                                 input string label);
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        a = model_regs[word[8:6]];
        b = model_regs[word[5:3]];
        if (model_writes(v, word)) begin
            add_row(v, word, 1'b1, word[11:9], model_alu(word, a, b), label);
        end else begin
            add_row(v, word, 1'b0, '0, '0, label);
        end
    endtask

    task automatic build_directed();
        // sources read as zero right after reset
        add_row(1'b1, reg_form(ALU_ADD, 3'd1, 3'd1, 3'd3), 1'b1, 3'd1, 8'h00, "reset");
        add_row(1'b1, imm_form(OP_ADDI, 3'd2, 3'd2, 6'h05), 1'b1, 3'd2, 8'h05, "reset");
        add_row(1'b1, reg_form(ALU_SUB, 3'd3, 3'd4, 3'd5), 1'b1, 3'd3, 8'h00, "reset");
        add_row(1'b1, imm_form(OP_XORI, 3'd4, 3'd6, 6'h3f), 1'b1, 3'd4, 8'hff, "reset");
        // every funct and immediate op
        add_row(1'b1, imm_form(OP_ADDI, 3'd5, 3'd7, 6'h1f), 1'b1, 3'd5, 8'h1f, "alu");
        // -32 sign-extends
        add_row(1'b1, imm_form(OP_ADDI, 3'd6, 3'd0, 6'h20), 1'b1, 3'd6, 8'he0, "alu");
        add_row(1'b1, reg_form(ALU_ADD, 3'd7, 3'd5, 3'd6), 1'b1, 3'd7, 8'hff, "alu");
        // 5 minus 31 wraps
        add_row(1'b1, reg_form(ALU_SUB, 3'd1, 3'd2, 3'd5), 1'b1, 3'd1, 8'he6, "alu");
        add_row(1'b1, reg_form(ALU_AND, 3'd3, 3'd4, 3'd6), 1'b1, 3'd3, 8'he0, "alu");
        add_row(1'b1, reg_form(ALU_OR, 3'd3, 3'd2, 3'd5), 1'b1, 3'd3, 8'h1f, "alu");
        add_row(1'b1, reg_form(ALU_XOR, 3'd3, 3'd6, 3'd5), 1'b1, 3'd3, 8'hff, "alu");
        add_row(1'b1, reg_form(ALU_SHL, 3'd1, 3'd2, 3'd2), 1'b1, 3'd1, 8'ha0, "alu");
        // shift amount 31 uses only its low bits
        add_row(1'b1, reg_form(ALU_SHR, 3'd1, 3'd6, 3'd5), 1'b1, 3'd1, 8'h01, "alu");
        add_row(1'b1, reg_form(ALU_SLT, 3'd1, 3'd2, 3'd5), 1'b1, 3'd1, 8'h01, "alu");
        // 0xff is not below 0x1f when unsigned
        add_row(1'b1, reg_form(ALU_SLT, 3'd1, 3'd4, 3'd5), 1'b1, 3'd1, 8'h00, "alu");
        add_row(1'b1, imm_form(OP_ANDI, 3'd2, 3'd7, 6'h0f), 1'b1, 3'd2, 8'h0f, "alu");
        add_row(1'b1, imm_form(OP_XORI, 3'd2, 3'd5, 6'h2a), 1'b1, 3'd2, 8'hf5, "alu");
        // dependency chain at distance 1, 2 and 3
        add_row(1'b1, imm_form(OP_ADDI, 3'd1, 3'd0, 6'h03), 1'b1, 3'd1, 8'h03, "hazard");
        add_row(1'b1, reg_form(ALU_ADD, 3'd2, 3'd1, 3'd1), 1'b1, 3'd2, 8'h06, "hazard");
        add_row(1'b1, reg_form(ALU_ADD, 3'd3, 3'd2, 3'd1), 1'b1, 3'd3, 8'h09, "hazard");
        add_row(1'b1, reg_form(ALU_SUB, 3'd4, 3'd3, 3'd1), 1'b1, 3'd4, 8'h06, "hazard");
        add_row(1'b1, reg_form(ALU_XOR, 3'd5, 3'd2, 3'd4), 1'b1, 3'd5, 8'h00, "hazard");
        add_row(1'b1, imm_form(OP_ADDI, 3'd5, 3'd5, 6'h3f), 1'b1, 3'd5, 8'hff, "hazard");
        add_row(1'b1, imm_form(OP_ADDI, 3'd6, 3'd4, 6'h01), 1'b1, 3'd6, 8'h07, "hazard");
        // forwarded shift amount on b
        add_row(1'b1, reg_form(ALU_SHL, 3'd7, 3'd6, 3'd6), 1'b1, 3'd7, 8'h80, "hazard");
        // nop, illegal, r0 targets, a bubble
        add_row(1'b1, 16'h0000, 1'b0, 3'd0, 8'h00, "no_write");
        add_row(1'b1, imm_form(4'hf, 3'd1, 3'd2, 6'h03), 1'b0, 3'd0, 8'h00, "no_write");
        add_row(1'b1, imm_form(OP_ADDI, 3'd0, 3'd6, 6'h05), 1'b0, 3'd0, 8'h00, "no_write");
        add_row(1'b1, reg_form(ALU_ADD, 3'd0, 3'd1, 3'd2), 1'b0, 3'd0, 8'h00, "no_write");
        add_row(1'b1, reg_form(ALU_ADD, 3'd1, 3'd0, 3'd0), 1'b1, 3'd1, 8'h00, "no_write");
        add_row(1'b0, imm_form(OP_ADDI, 3'd2, 3'd0, 6'h01), 1'b0, 3'd0, 8'h00, "no_write");
        add_row(1'b1, imm_form(OP_ADDI, 3'd2, 3'd1, 6'h04), 1'b1, 3'd2, 8'h04, "no_write");
        add_row(1'b1, reg_form(ALU_SUB, 3'd3, 3'd0, 3'd2), 1'b1, 3'd3, 8'hfc, "no_write");
    endtask

    task automatic build_random();
        logic [`INSTR_W-1:0] word;
        logic [3:0]          op;
        logic                v;
        for (int i = 0; i < N_RANDOM; i++) begin
            seed = xorshift(seed);
            // about one bubble in four
            v = (seed[1:0] != 2'b00);
            case (seed[4:2])
                3'd0, 3'd1, 3'd2: op = OP_ALU_REG;
                3'd3: op = OP_ADDI;
                3'd4: op = OP_ANDI;
                3'd5: op = OP_XORI;
                3'd6: op = OP_NOP;
                default: op = 4'h9;
            endcase
            word = {op, seed[18:16], seed[21:19], seed[27:22]};
            add_model_row(v, word, "random");
        end
    endtask

    task automatic check_value(input string name, input logic [`DATA_W-1:0] got,
                               input logic [`DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h at row %0d (%s)",
                     name, got, exp, cur_row, tab_label[cur_row]);
        end
    endtask

    task automatic check_row(input int r);
        logic group_end;
        cur_row = r;
        check_value("wb_valid", {{(`DATA_W-1){1'b0}}, wb_valid},
                    {{(`DATA_W-1){1'b0}}, tab_exp_valid[r]});
        // dest and data only mean something on a retirement
        if (tab_exp_valid[r]) begin
            check_value("wb_dest", {{(`DATA_W-`REG_ADDR_W){1'b0}}, wb_dest},
                        {{(`DATA_W-`REG_ADDR_W){1'b0}}, tab_exp_dest[r]});
            check_value("wb_data", wb_data, tab_exp_data[r]);
        end
        group_end = (r == n_rows - 1);
        if (!group_end) begin
            group_end = (tab_label[r] != tab_label[r + 1]);
        end
        if (group_end) begin
            $display("test %s: %0d rows, %0d errors", tab_label[r],
                     r - group_first + 1, errors - group_errors);
            group_first  = r + 1;
            group_errors = errors;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        build_directed();
        build_random();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // nothing retires straight out of reset
        check_value("wb_valid", {{(`DATA_W-1){1'b0}}, wb_valid}, '0);
        // row k is driven here and checked two falling edges later
        for (int k = 0; k < n_rows + 2; k++) begin
            @(negedge clk);
            if (k >= 2) begin
                check_row(k - 2);
            end
            if (k < n_rows) begin
                instr_valid = tab_valid[k];
                instr       = tab_instr[k];
            end else begin
                instr_valid = 1'b0;
                instr       = '0;
            end
        end
        $display("rows %0d, checks %0d, errors %0d", n_rows, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: cpu8.f
+incdir+common
common/cpu8_pkg.sv
rtl/reg_bank.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/cpu8_core.sv
tests/cpu8_tb.sv

// File: Makefile
# Verilator build and run of the cpu8 testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cpu8_tb
FILELIST  ?= cpu8.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run passes only if the pass line appears in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
